//--- design/ibex_shell_pkg.sv
// Shared widths, default cache geometry and key exchange state.
// Cache defaults only seed the top level parameters and may be overridden there.

package ibex_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  // Address covers 32 registers, RV32E uses the low 16 only
  parameter int unsigned REG_ADDR_W = 5;
  parameter int unsigned REG_DATA_W = 32;

  ////////////////////////////////////////////////////////////
  // Instruction cache geometry
  ////////////////////////////////////////////////////////////

  parameter int unsigned IC_NUM_WAYS_DEFAULT  = 2;
  parameter int unsigned IC_NUM_LINES_DEFAULT = 256;

  // Tag entry including its valid bit
  parameter int unsigned IC_TAG_W_DEFAULT = 22;

  // Two 32-bit bus beats per line
  parameter int unsigned IC_LINE_W_DEFAULT = 64;

  ////////////////////////////////////////////////////////////
  // Scrambling key exchange
  ////////////////////////////////////////////////////////////

  // Key is valid out of reset, a cache request moves to KEY_REQUEST
  typedef enum logic {
    KEY_VALID   = 1'b0,
    KEY_REQUEST = 1'b1
  } scr_key_state_e;

endpackage

//--- design/ibex_shell_top.sv
// Shell around the processor pipeline, which stays outside this block.
// Register file sits on the gated clock, cache banks on the free clock.
// NumLines sets the cache index width, one tag and one data bank per way.

module ibex_shell_top #(
  parameter bit          RV32E     = 1'b0,
  parameter int unsigned NumWays   = ibex_shell_pkg::IC_NUM_WAYS_DEFAULT,
  parameter int unsigned NumLines  = ibex_shell_pkg::IC_NUM_LINES_DEFAULT,
  parameter int unsigned TagWidth  = ibex_shell_pkg::IC_TAG_W_DEFAULT,
  parameter int unsigned LineWidth = ibex_shell_pkg::IC_LINE_W_DEFAULT
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Wake sources
  input  logic                                  core_busy_i,
  input  logic                                  irq_pending_i,
  input  logic                                  irq_nm_i,
  input  logic                                  debug_req_i,
  output logic                                  core_sleep_o,

  // Register file
  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [ibex_shell_pkg::REG_DATA_W-1:0] wdata_i,
  input  logic                                  we_i,
  output logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_a_o,
  output logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_b_o,

  // Cache tag banks
  input  logic [NumWays-1:0]                    ic_tag_req_i,
  input  logic                                  ic_tag_write_i,
  input  logic [$clog2(NumLines)-1:0]           ic_tag_addr_i,
  input  logic [TagWidth-1:0]                   ic_tag_wdata_i,
  output logic [NumWays-1:0][TagWidth-1:0]      ic_tag_rdata_o,

  // Cache data banks
  input  logic [NumWays-1:0]                    ic_data_req_i,
  input  logic                                  ic_data_write_i,
  input  logic [$clog2(NumLines)-1:0]           ic_data_addr_i,
  input  logic [LineWidth-1:0]                  ic_data_wdata_i,
  output logic [NumWays-1:0][LineWidth-1:0]     ic_data_rdata_o,

  // Scrambling key exchange
  input  logic                                  ic_scr_key_req_i,
  input  logic                                  scramble_key_valid_i,
  output logic                                  scramble_req_o,
  output logic                                  ic_scr_key_valid_o
);

  // Gated core clock
  logic clk_core;

  ////////////////////////////////////////////////////////////
  // Sleep, clock gate and key exchange
  ////////////////////////////////////////////////////////////

  shell_ctrl u_shell_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .core_busy_i         (core_busy_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .debug_req_i         (debug_req_i),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .clk_core_o          (clk_core),
    .core_sleep_o        (core_sleep_o),
    .scramble_req_o      (scramble_req_o),
    .ic_scr_key_valid_o  (ic_scr_key_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  regfile_ff #(
    .RV32E(RV32E)
  ) u_regfile (
    .clk_i    (clk_core),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i),
    .we_i     (we_i),
    .rdata_a_o(rdata_a_o),
    .rdata_b_o(rdata_b_o)
  );

  ////////////////////////////////////////////////////////////
  // Cache RAM banks
  ////////////////////////////////////////////////////////////

  // Address, write and write data are shared, the request selects the way
  for (genvar way = 0; way < NumWays; way++) begin : gen_ways

    icache_ram_1p #(
      .Width(TagWidth),
      .Depth(NumLines)
    ) u_tag_bank (
      .clk_i  (clk_i),
      .req_i  (ic_tag_req_i[way]),
      .write_i(ic_tag_write_i),
      .addr_i (ic_tag_addr_i),
      .wdata_i(ic_tag_wdata_i),
      .rdata_o(ic_tag_rdata_o[way])
    );

    icache_ram_1p #(
      .Width(LineWidth),
      .Depth(NumLines)
    ) u_data_bank (
      .clk_i  (clk_i),
      .req_i  (ic_data_req_i[way]),
      .write_i(ic_data_write_i),
      .addr_i (ic_data_addr_i),
      .wdata_i(ic_data_wdata_i),
      .rdata_o(ic_data_rdata_o[way])
    );

  end

endmodule

//--- design/icache_ram_1p.sv
// Single-port synchronous RAM for one cache tag or data bank.
// Contents are undefined after power-up, there is no reset or init.
// Read data holds its value until the next read request.

module icache_ram_1p #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 256
) (
  input  logic                     clk_i,

  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [Width-1:0]         wdata_i,

  output logic [Width-1:0]         rdata_o
);

  logic [Width-1:0] mem [Depth];

  // Whole-word writes, no byte mask
  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // Read data registered, valid the cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- design/regfile_ff.sv
// Flip-flop register file, two combinational reads and one write port.
// Clocked by the gated core clock, so writes during sleep are dropped.
// With RV32E the top address bit is ignored and registers alias.

module regfile_ff #(
  parameter bit RV32E = 1'b0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [ibex_shell_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [ibex_shell_pkg::REG_DATA_W-1:0] wdata_i,
  input  logic                                  we_i,

  output logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_a_o,
  output logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_b_o
);

  import ibex_shell_pkg::*;

  localparam int unsigned NumRegs  = RV32E ? 16 : 32;
  localparam int unsigned AddrUsed = $clog2(NumRegs);

  // Registers 1 upward, register zero is not stored
  logic [NumRegs-1:1][REG_DATA_W-1:0] rf_q;
  logic [NumRegs-1:0][REG_DATA_W-1:0] rf_all;
  logic [NumRegs-1:1]                 we_dec;

  // Write address decode
  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = we_i && (waddr_i[AddrUsed-1:0] == AddrUsed'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_q <= '0;
    end else begin
      for (int unsigned i = 1; i < NumRegs; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wdata_i;
        end
      end
    end
  end

  // Zero register tied off below the stored ones
  assign rf_all = {rf_q, REG_DATA_W'(0)};

  assign rdata_a_o = rf_all[raddr_a_i[AddrUsed-1:0]];
  assign rdata_b_o = rf_all[raddr_b_i[AddrUsed-1:0]];

endmodule

//--- design/shell_ctrl.sv
// Sleep decision, latch-based clock gate and key exchange FSM.
// Gate has no test-enable bypass, so scan needs a separate clock path.
// Key requester must hold its request until the key comes back valid.

module shell_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // Wake sources from the pipeline and the outside
  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic debug_req_i,

  // Key exchange
  input  logic ic_scr_key_req_i,
  input  logic scramble_key_valid_i,

  output logic clk_core_o,
  output logic core_sleep_o,
  output logic scramble_req_o,
  output logic ic_scr_key_valid_o
);

  import ibex_shell_pkg::*;

  logic           core_busy_q;
  logic           clock_en;
  logic           clock_en_latched;
  scr_key_state_e key_state_q;
  scr_key_state_e key_state_d;

  ////////////////////////////////////////////////////////////
  // Sleep and clock gate
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the core clock running
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Transparent while clk_i is low, holds through the high phase
  always_latch begin
    if (!clk_i) begin
      clock_en_latched <= clock_en;
    end
  end

  // Glitch free since the enable only moves while clk_i is low
  assign clk_core_o = clk_i & clock_en_latched;

  ////////////////////////////////////////////////////////////
  // Scrambling key exchange
  ////////////////////////////////////////////////////////////

  always_comb begin
    key_state_d = key_state_q;
    unique case (key_state_q)
      KEY_VALID: begin
        // Cache invalidation asks for a fresh key
        if (ic_scr_key_req_i) begin
          key_state_d = KEY_REQUEST;
        end
      end
      KEY_REQUEST: begin
        if (scramble_key_valid_i) begin
          key_state_d = KEY_VALID;
        end
      end
    endcase
  end

  // Runs on the free clock so a sleeping core still gets its key
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_state_q <= KEY_VALID;
    end else begin
      key_state_q <= key_state_d;
    end
  end

  assign scramble_req_o     = (key_state_q == KEY_REQUEST);
  assign ic_scr_key_valid_o = (key_state_q == KEY_VALID);

endmodule

//--- flist.f
design/ibex_shell_pkg.sv
design/shell_ctrl.sv
design/regfile_ff.sv
design/icache_ram_1p.sv
design/ibex_shell_top.sv
testbench/ibex_shell_sva.sv
testbench/tb_ibex_shell.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_ibex_shell \
  -f flist.f \
  -o Vtb_ibex_shell

# SVA errors are counted so the testbench can end the run itself
./obj_dir/Vtb_ibex_shell +verilator+error+limit+100

//--- testbench/ibex_shell_sva.sv
// Concurrent checks on the sleep rule, key exchange and reset values.
// Sampled on the free clock, gated edges are not observed here.
// Each property sets its own sticky flag, fail_seen is their OR.

module ibex_shell_sva (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  core_busy_i,
  input  logic                                  irq_pending_i,
  input  logic                                  irq_nm_i,
  input  logic                                  debug_req_i,
  input  logic                                  core_sleep_o,
  input  logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_a_o,
  input  logic [ibex_shell_pkg::REG_DATA_W-1:0] rdata_b_o,
  input  logic                                  ic_scr_key_req_i,
  input  logic                                  scramble_key_valid_i,
  input  logic                                  scramble_req_o,
  input  logic                                  ic_scr_key_valid_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic reset_key_err  = 1'b0;
  logic reset_rf_err   = 1'b0;
  logic after_rst_err  = 1'b0;
  logic sleep_err      = 1'b0;
  logic key_enter_err  = 1'b0;
  logic key_hold_err   = 1'b0;
  logic key_leave_err  = 1'b0;
  logic fail_seen;

  assign fail_seen = reset_key_err | reset_rf_err | after_rst_err | sleep_err
                     | key_enter_err | key_hold_err | key_leave_err;

  ////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////

  reset_key_a: assert property (@(posedge clk_i)
    !rst_ni |-> (!scramble_req_o && ic_scr_key_valid_o))
    else begin
      reset_key_err = 1'b1;
      $error("Key exchange outputs not at reset values during reset");
    end

  reset_rf_a: assert property (@(posedge clk_i)
    !rst_ni |-> (rdata_a_o == '0 && rdata_b_o == '0))
    else begin
      reset_rf_err = 1'b1;
      $error("Register file reads nonzero during reset");
    end

  after_rst_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!scramble_req_o && ic_scr_key_valid_o))
    else begin
      after_rst_err = 1'b1;
      $error("Key exchange outputs wrong right after reset");
    end

  ////////////////////////////////////////////////////////////
  // Sleep rule
  ////////////////////////////////////////////////////////////

  // Busy reaches the enable through one flop, the other sources directly
  sleep_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o == !($past(core_busy_i) || debug_req_i || irq_pending_i || irq_nm_i))
    else begin
      sleep_err = 1'b1;
      $error("core_sleep_o does not follow the wake sources");
    end

  ////////////////////////////////////////////////////////////
  // Key exchange
  ////////////////////////////////////////////////////////////

  key_enter_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ic_scr_key_valid_o && ic_scr_key_req_i) |=> (scramble_req_o && !ic_scr_key_valid_o))
    else begin
      key_enter_err = 1'b1;
      $error("Key request did not move the exchange to the request state");
    end

  key_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scramble_req_o && !scramble_key_valid_i) |=> (scramble_req_o && !ic_scr_key_valid_o))
    else begin
      key_hold_err = 1'b1;
      $error("Key request dropped before the key became valid");
    end

  key_leave_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scramble_req_o && scramble_key_valid_i) |=> (!scramble_req_o && ic_scr_key_valid_o))
    else begin
      key_leave_err = 1'b1;
      $error("Valid key did not return the exchange to the valid state");
    end

endmodule

//--- testbench/tb_ibex_shell.sv
// Drives the shell with xorshift stimulus and checks shadow models.
// Inputs change 1 ns after the rising edge, reads are checked mid-cycle.
// Sleep, key exchange and reset values are checked by the bound SVA module.

module tb_ibex_shell;

  timeunit 1ns;
  timeprecision 100ps;

  import ibex_shell_pkg::*;

  localparam int unsigned NUM_WAYS     = IC_NUM_WAYS_DEFAULT;
  localparam int unsigned NUM_LINES    = IC_NUM_LINES_DEFAULT;
  localparam int unsigned TAG_W        = IC_TAG_W_DEFAULT;
  localparam int unsigned LINE_W       = IC_LINE_W_DEFAULT;
  localparam int unsigned LINE_AW      = $clog2(NUM_LINES);
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned RF_OPS       = 400;
  localparam int unsigned RAM_OPS      = 64;
  localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + RF_OPS + 2
                                         + RAM_OPS * (NUM_WAYS + 2) + 8;
  localparam int unsigned CYCLE_LIMIT  = 4 * TOTAL_CYCLES;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             core_busy_i;
  logic                             irq_pending_i;
  logic                             irq_nm_i;
  logic                             debug_req_i;
  logic                             core_sleep_o;
  logic [REG_ADDR_W-1:0]            raddr_a_i;
  logic [REG_ADDR_W-1:0]            raddr_b_i;
  logic [REG_ADDR_W-1:0]            waddr_i;
  logic [REG_DATA_W-1:0]            wdata_i;
  logic                             we_i;
  logic [REG_DATA_W-1:0]            rdata_a_o;
  logic [REG_DATA_W-1:0]            rdata_b_o;
  logic [NUM_WAYS-1:0]              ic_tag_req_i;
  logic                             ic_tag_write_i;
  logic [LINE_AW-1:0]               ic_tag_addr_i;
  logic [TAG_W-1:0]                 ic_tag_wdata_i;
  logic [NUM_WAYS-1:0][TAG_W-1:0]   ic_tag_rdata_o;
  logic [NUM_WAYS-1:0]              ic_data_req_i;
  logic                             ic_data_write_i;
  logic [LINE_AW-1:0]               ic_data_addr_i;
  logic [LINE_W-1:0]                ic_data_wdata_i;
  logic [NUM_WAYS-1:0][LINE_W-1:0]  ic_data_rdata_o;
  logic                             ic_scr_key_req_i;
  logic                             scramble_key_valid_i;
  logic                             scramble_req_o;
  logic                             ic_scr_key_valid_o;

  logic [31:0]           rng_state;
  int unsigned           cycle_cnt = 0;
  // Busy as driven one cycle earlier to mirror the registered busy
  logic                  busy_prev;
  // Gate enable seen by the next rising edge
  logic                  en_cur;
  logic [REG_DATA_W-1:0] rf_model [32];
  logic [TAG_W-1:0]      tag_model [NUM_WAYS][NUM_LINES];
  logic [LINE_W-1:0]     data_model [NUM_WAYS][NUM_LINES];

  ibex_shell_top #(
    .RV32E    (1'b0),
    .NumWays  (NUM_WAYS),
    .NumLines (NUM_LINES),
    .TagWidth (TAG_W),
    .LineWidth(LINE_W)
  ) uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .core_busy_i         (core_busy_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .debug_req_i         (debug_req_i),
    .core_sleep_o        (core_sleep_o),
    .raddr_a_i           (raddr_a_i),
    .raddr_b_i           (raddr_b_i),
    .waddr_i             (waddr_i),
    .wdata_i             (wdata_i),
    .we_i                (we_i),
    .rdata_a_o           (rdata_a_o),
    .rdata_b_o           (rdata_b_o),
    .ic_tag_req_i        (ic_tag_req_i),
    .ic_tag_write_i      (ic_tag_write_i),
    .ic_tag_addr_i       (ic_tag_addr_i),
    .ic_tag_wdata_i      (ic_tag_wdata_i),
    .ic_tag_rdata_o      (ic_tag_rdata_o),
    .ic_data_req_i       (ic_data_req_i),
    .ic_data_write_i     (ic_data_write_i),
    .ic_data_addr_i      (ic_data_addr_i),
    .ic_data_wdata_i     (ic_data_wdata_i),
    .ic_data_rdata_o     (ic_data_rdata_o),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_req_o      (scramble_req_o),
    .ic_scr_key_valid_o  (ic_scr_key_valid_o)
  );

  bind ibex_shell_top ibex_shell_sva u_sva (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .core_busy_i         (core_busy_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .debug_req_i         (debug_req_i),
    .core_sleep_o        (core_sleep_o),
    .rdata_a_o           (rdata_a_o),
    .rdata_b_o           (rdata_b_o),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_req_o      (scramble_req_o),
    .ic_scr_key_valid_o  (ic_scr_key_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and error exits
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    abort_run();
  endtask

  // Cycle budget of four times the planned run
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  always @(negedge clk_i) begin
    if (uut.u_sva.fail_seen) begin
      $display("A bound SVA property on the shell failed at t=%0t", $time);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic init_inputs();
    rst_ni               = 1'b0;
    core_busy_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    debug_req_i          = 1'b0;
    raddr_a_i            = '0;
    raddr_b_i            = '0;
    waddr_i              = '0;
    wdata_i              = '0;
    we_i                 = 1'b0;
    ic_tag_req_i         = '0;
    ic_tag_write_i       = 1'b0;
    ic_tag_addr_i        = '0;
    ic_tag_wdata_i       = '0;
    ic_data_req_i        = '0;
    ic_data_write_i      = 1'b0;
    ic_data_addr_i       = '0;
    ic_data_wdata_i      = '0;
    ic_scr_key_req_i     = 1'b0;
    scramble_key_valid_i = 1'b0;
    busy_prev            = 1'b0;
    en_cur               = 1'b0;
  endtask

  // Wake sources and key exchange redrawn every cycle
  task automatic drive_background();
    logic [31:0] r;
    r = next_rand();
    busy_prev     = core_busy_i;
    core_busy_i   = r[0];
    debug_req_i   = (r[3:1] == 3'd0);
    irq_pending_i = (r[6:4] == 3'd0);
    irq_nm_i      = (r[10:7] == 4'd0);
    // Requester holds until the key returns
    ic_scr_key_req_i     = scramble_req_o | (r[13:11] == 3'd0);
    scramble_key_valid_i = (r[15:14] == 2'd0);
    en_cur = busy_prev | debug_req_i | irq_pending_i | irq_nm_i;
  endtask

  // Applies the write that the last rising edge saw
  task automatic regfile_edge();
    @(posedge clk_i);
    if (en_cur && we_i && waddr_i != '0) begin
      rf_model[waddr_i] = wdata_i;
    end
  endtask

  task automatic run_regfile_phase();
    logic [31:0]           r;
    logic [REG_ADDR_W-1:0] last_waddr;
    last_waddr = '0;
    for (int i = 0; i < RF_OPS; i++) begin
      regfile_edge();
      #1;
      drive_background();
      r         = next_rand();
      we_i      = r[0] | r[1];
      waddr_i   = (i % 16 == 0) ? '0 : r[6:2];
      wdata_i   = next_rand();
      // Port A reads back the previous write while port B roams
      raddr_a_i = last_waddr;
      raddr_b_i = r[11:7];
      last_waddr = waddr_i;
      #4;
      assert (rdata_a_o == rf_model[raddr_a_i])
        else report_mismatch("rdata_a_o", 64'(rf_model[raddr_a_i]), 64'(rdata_a_o));
      assert (rdata_b_o == rf_model[raddr_b_i])
        else report_mismatch("rdata_b_o", 64'(rf_model[raddr_b_i]), 64'(rdata_b_o));
    end
    regfile_edge();
    #1;
    we_i = 1'b0;
  endtask

  task automatic check_ram_line(input logic [LINE_AW-1:0] line);
    for (int w = 0; w < NUM_WAYS; w++) begin
      assert (ic_tag_rdata_o[w] == tag_model[w][line])
        else report_mismatch($sformatf("ic_tag_rdata_o[%0d]", w),
                             64'(tag_model[w][line]), 64'(ic_tag_rdata_o[w]));
      assert (ic_data_rdata_o[w] == data_model[w][line])
        else report_mismatch($sformatf("ic_data_rdata_o[%0d]", w),
                             64'(data_model[w][line]), 64'(ic_data_rdata_o[w]));
    end
  endtask

  task automatic run_ram_phase();
    logic [LINE_AW-1:0] line;
    logic [LINE_AW-1:0] lines [$];
    logic [31:0]        lo;
    logic [31:0]        hi;
    // Same line in every way with one way per cycle and its own data
    for (int i = 0; i < RAM_OPS; i++) begin
      line = LINE_AW'(next_rand());
      lines.push_back(line);
      for (int w = 0; w < NUM_WAYS; w++) begin
        @(posedge clk_i);
        #1;
        drive_background();
        lo = next_rand();
        hi = next_rand();
        ic_tag_req_i       = '0;
        ic_tag_req_i[w]    = 1'b1;
        ic_data_req_i      = ic_tag_req_i;
        ic_tag_write_i     = 1'b1;
        ic_data_write_i    = 1'b1;
        ic_tag_addr_i      = line;
        ic_data_addr_i     = line;
        ic_tag_wdata_i     = TAG_W'(lo);
        ic_data_wdata_i    = LINE_W'({hi, lo});
        tag_model[w][line]  = ic_tag_wdata_i;
        data_model[w][line] = ic_data_wdata_i;
      end
    end
    // Read all ways together and check one cycle after the request
    foreach (lines[i]) begin
      @(posedge clk_i);
      #1;
      drive_background();
      ic_tag_req_i    = '1;
      ic_data_req_i   = '1;
      ic_tag_write_i  = 1'b0;
      ic_data_write_i = 1'b0;
      ic_tag_addr_i   = lines[i];
      ic_data_addr_i  = lines[i];
      @(posedge clk_i);
      #1;
      drive_background();
      ic_tag_req_i  = '0;
      ic_data_req_i = '0;
      #4;
      check_ram_line(lines[i]);
    end
  endtask

  initial begin
    rng_state = 32'd13348;
    init_inputs();
    for (int i = 0; i < 32; i++) begin
      rf_model[i] = '0;
    end
    // Read ports roam while reset holds every register at zero
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      #1;
      raddr_a_i = REG_ADDR_W'(next_rand());
      raddr_b_i = REG_ADDR_W'(next_rand());
    end
    rst_ni = 1'b1;
    run_regfile_phase();
    run_ram_phase();
    repeat (4) @(posedge clk_i);
    // Let the properties sampled on the last edge settle
    #1;
    if (uut.u_sva.fail_seen) begin
      $display("A bound SVA property on the shell failed before the end");
      abort_run();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
